// ==== wb_reg_bank.f ====
+incdir+.
wb_reg_pkg.sv
cdc_handshake.sv
ctrl_reg_path.sv
status_reg_path.sv
wb_bus_slave.sv
wb_reg_bank.sv
tb_wb_reg_bank.sv

// ==== Makefile ====
# Verilator flow for the Wishbone register bank.
VERILATOR ?= verilator
FILELIST  ?= wb_reg_bank.f
TB_TOP    ?= tb_wb_reg_bank
RTL_TOP   ?= wb_reg_bank
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
	  echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -q "Simulation passed" $(LOG); then \
	  echo "FAIL: run ended without a result, see $(LOG)"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_wb_reg_bank.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module tb_wb_reg_bank import wb_reg_pkg::*; ();

  localparam int NUM_CTRL_WR     = 40;
  localparam int NUM_BURST       = 8;
  localparam int NUM_STAT        = 50;
  localparam int NUM_ERR         = 15;
  localparam int STAT_POLL_MAX   = 40;
  localparam int NUM_OPS         = 6 + 2 * NUM_CTRL_WR + NUM_BURST + NUM_STAT
                                   + 2 * STAT_POLL_MAX + NUM_ERR;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 60 + 2000;
  localparam logic [31:0] SEED     = 32'h1f4d;
  localparam logic [31:0] ADR_CTRL = {28'd0, `ADDR_CTRL, 2'b00};
  localparam logic [31:0] ADR_STAT = {28'd0, `ADDR_STAT, 2'b00};
  localparam logic [31:0] ADR_SEQ  = {28'd0, `ADDR_SEQ, 2'b00};
  localparam logic [31:0] ADR_W3   = 32'h0000_000c;  // First word past the map.

  logic              wb_clk_i;
  logic              user_clk;
  logic              wb_rst_i;
  logic [`WB_DW-1:0] wb_adr_i;
  logic [`WB_DW-1:0] wb_dat_i;
  byte_sel_t         wb_sel_i;
  logic              wb_we_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic [`WB_DW-1:0] wb_dat_o;
  logic              wb_ack_o;
  logic              wb_err_o;
  logic [`WB_DW-1:0] user_data_i;
  logic              user_valid_i;
  logic [`WB_DW-1:0] user_data_o;
  logic              user_update_o;

  ctrl_word_t  ctrl_model;     // Expected control buffer.
  ctrl_word_t  ctrl_hist[$];   // Every value the buffer has held.
  logic [31:0] stat_model;
  seq_cnt_t    seq_model;
  int          update_count;
  logic        reset_done;

  wb_reg_bank i_wb_reg_bank (.*);

  always #7 wb_clk_i = ~wb_clk_i;
  always #5 user_clk = ~user_clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "Run stopped at the first error.");
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch in %s: expected 0x%08h, actual 0x%08h", name, exp, act));
    end
  endtask

  function automatic ctrl_word_t merge_lanes(input ctrl_word_t old, input ctrl_word_t dat,
                                             input byte_sel_t sel);
    ctrl_word_t res;
    res = old;
    for (int lane = 0; lane < 4; lane++) begin
      if (sel[lane]) begin
        res[lane*8 +: 8] = dat[lane*8 +: 8];  // Lane 3 is bits 31:24.
      end
    end
    return res;
  endfunction

  function automatic bit in_history(input ctrl_word_t value);
    foreach (ctrl_hist[i]) begin
      if (ctrl_hist[i] == value) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // One access; the response must show up one cycle later and last one cycle.
  task automatic bus_access(input string name, input logic we, input logic [31:0] adr,
                            input logic [31:0] dat, input byte_sel_t sel,
                            input logic want_err, output logic [31:0] rdat);
    logic ack;
    logic err;
    @(negedge wb_clk_i);
    if (wb_ack_o || wb_err_o) begin
      abort_run($sformatf("%s: a response was up before the request", name));
    end
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(negedge wb_clk_i);
    ack  = wb_ack_o;
    err  = wb_err_o;
    rdat = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (!ack && !err) begin
      abort_run($sformatf("%s: no ack or err one cycle after the request", name));
    end
    check_eq({name, " ack"}, {31'd0, !want_err}, {31'd0, ack});
    check_eq({name, " err"}, {31'd0, want_err}, {31'd0, err});
    if (want_err) begin
      check_eq({name, " err data"}, 32'd0, rdat);
    end
    @(negedge wb_clk_i);
    if (wb_ack_o || wb_err_o) begin
      abort_run($sformatf("%s: response lasted more than one cycle", name));
    end
    check_eq({name, " idle data"}, 32'd0, wb_dat_o);
  endtask

  task automatic bus_write(input string name, input logic [31:0] adr, input logic [31:0] dat,
                           input byte_sel_t sel, input logic want_err);
    logic [31:0] rdat;
    if (!want_err) begin
      ctrl_model = merge_lanes(ctrl_model, dat, sel);
      ctrl_hist.push_back(ctrl_model);
    end
    bus_access(name, 1'b1, adr, dat, sel, want_err, rdat);
  endtask

  task automatic bus_read(input string name, input logic [31:0] adr, input logic want_err,
                          output logic [31:0] rdat);
    bus_access(name, 1'b0, adr, 32'd0, 4'h0, want_err, rdat);
  endtask

  // Every arrival in the user domain must be a value the buffer once held.
  always @(negedge user_clk) begin
    if (reset_done && user_update_o === 1'b1) begin
      update_count = update_count + 1;
      if (!in_history(user_data_o)) begin
        abort_run($sformatf("user_data_o shows 0x%08h, which the control word never held",
                            user_data_o));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
    abort_run("Timeout: the test sequence did not finish before the watchdog expired");
  end

  initial begin
    logic [31:0] rdat;
    logic [31:0] rd_stat;
    logic [31:0] rd_seq;
    int          gap;
    int          count_before;
    void'($urandom(SEED));
    wb_clk_i     = 1'b0;
    user_clk     = 1'b0;
    wb_rst_i     = 1'b1;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = '0;
    wb_we_i      = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    user_data_i  = '0;
    user_valid_i = 1'b0;
    ctrl_model   = '0;
    stat_model   = '0;
    seq_model    = '0;
    update_count = 0;
    reset_done   = 1'b0;
    ctrl_hist.push_back('0);
    repeat (10) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    repeat (4) @(negedge user_clk);  // User-side reset copy clears.
    reset_done = 1'b1;

    // Reset state.
    bus_read("reset word 0", ADR_CTRL, 1'b0, rdat);
    check_eq("reset word 0", 32'd0, rdat);
    bus_read("reset word 1", ADR_STAT, 1'b0, rdat);
    check_eq("reset word 1", 32'd0, rdat);
    bus_read("reset word 2", ADR_SEQ, 1'b0, rdat);
    check_eq("reset word 2", 32'd0, rdat);
    check_eq("reset user_update_o pulses", 32'd0, update_count);

    // Byte-lane writes with read-back.
    for (int i = 0; i < NUM_CTRL_WR; i++) begin
      bus_write("ctrl write", ADR_CTRL, $urandom, byte_sel_t'($urandom), 1'b0);
      bus_read("ctrl read-back", ADR_CTRL, 1'b0, rdat);
      check_eq("ctrl read-back", ctrl_model, rdat);
    end

    // Burst, then the final word must reach the user side.
    count_before = update_count;
    for (int i = 0; i < NUM_BURST; i++) begin
      bus_write("ctrl burst", ADR_CTRL, $urandom, 4'hf, 1'b0);
    end
    for (int i = 0; i < 100; i++) begin
      @(negedge user_clk);
      if (user_data_o === ctrl_model) begin
        break;
      end
    end
    repeat (2) @(negedge user_clk);
    check_eq("ctrl crossing final value", ctrl_model, user_data_o);
    if (update_count == count_before) begin
      abort_run("No user_update_o pulse after the control write burst");
    end

    // Status samples with random gaps.
    for (int i = 0; i < NUM_STAT; i++) begin
      @(negedge user_clk);
      user_data_i  = $urandom;
      user_valid_i = 1'b1;
      stat_model   = user_data_i;
      seq_model    = seq_model + seq_cnt_t'(1);
      gap = int'($urandom_range(3, 0));
      if (gap != 0) begin
        @(negedge user_clk);
        user_valid_i = 1'b0;
        repeat (gap - 1) @(negedge user_clk);
      end
    end
    @(negedge user_clk);
    user_valid_i = 1'b0;
    for (int i = 0; i < STAT_POLL_MAX; i++) begin
      bus_read("status poll", ADR_STAT, 1'b0, rd_stat);
      bus_read("sequence poll", ADR_SEQ, 1'b0, rd_seq);
      if (rd_stat === stat_model && rd_seq === 32'(seq_model)) begin
        break;
      end
    end
    check_eq("status word", stat_model, rd_stat);
    check_eq("sequence word", 32'(seq_model), rd_seq);

    // Illegal accesses.
    count_before = update_count;
    for (int i = 0; i < NUM_ERR; i++) begin
      case (i % 5)
        0: bus_write("write to status word", ADR_STAT, $urandom, 4'hf, 1'b1);
        1: bus_write("write to sequence word", ADR_SEQ, $urandom, 4'hf, 1'b1);
        2: bus_read("read of word 3", ADR_W3, 1'b1, rdat);
        3: bus_write("write to word 3", ADR_W3, $urandom, 4'hf, 1'b1);
        default: bus_read("read beyond map", $urandom | 32'h10, 1'b1, rdat);
      endcase
    end
    bus_read("word 0 after errors", ADR_CTRL, 1'b0, rdat);
    check_eq("word 0 after errors", ctrl_model, rdat);
    bus_read("word 1 after errors", ADR_STAT, 1'b0, rdat);
    check_eq("word 1 after errors", stat_model, rdat);
    bus_read("word 2 after errors", ADR_SEQ, 1'b0, rdat);
    check_eq("word 2 after errors", 32'(seq_model), rdat);
    repeat (20) @(posedge user_clk);
    check_eq("user updates after errors", count_before, update_count);

    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== wb_reg_bank.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module wb_reg_bank import wb_reg_pkg::*; (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic [`WB_DW-1:0] wb_adr_i,
  input  logic [`WB_DW-1:0] wb_dat_i,
  input  byte_sel_t         wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  input  logic              user_clk,
  input  logic [`WB_DW-1:0] user_data_i,
  input  logic              user_valid_i,
  output logic [`WB_DW-1:0] user_data_o,
  output logic              user_update_o
);

  logic              ctrl_wr;    // Legal control write strobe.
  ctrl_word_t        ctrl_dat;
  byte_sel_t         ctrl_sel;
  ctrl_word_t        ctrl_word;  // Control buffer read-back.
  logic [`WB_DW-1:0] stat_word;
  seq_cnt_t          seq_cnt;

  wb_bus_slave i_wb_bus_slave (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_sel_i   (wb_sel_i),
    .wb_we_i    (wb_we_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .ctrl_i     (ctrl_word),
    .stat_i     (stat_word),
    .seq_i      (seq_cnt),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_err_o   (wb_err_o),
    .ctrl_wr_o  (ctrl_wr),
    .ctrl_dat_o (ctrl_dat),
    .ctrl_sel_o (ctrl_sel)
  );

  ctrl_reg_path i_ctrl_reg_path (
    .wb_clk_i      (wb_clk_i),
    .wb_rst_i      (wb_rst_i),
    .user_clk      (user_clk),
    .wr_i          (ctrl_wr),
    .wr_dat_i      (ctrl_dat),
    .wr_sel_i      (ctrl_sel),
    .ctrl_o        (ctrl_word),
    .user_data_o   (user_data_o),
    .user_update_o (user_update_o)
  );

  status_reg_path i_status_reg_path (
    .user_clk     (user_clk),
    .wb_clk_i     (wb_clk_i),
    .wb_rst_i     (wb_rst_i),
    .user_data_i  (user_data_i),
    .user_valid_i (user_valid_i),
    .stat_o       (stat_word),
    .seq_o        (seq_cnt)
  );

endmodule

// ==== wb_bus_slave.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module wb_bus_slave import wb_reg_pkg::*; (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic [`WB_DW-1:0] wb_adr_i,
  input  logic [`WB_DW-1:0] wb_dat_i,
  input  byte_sel_t         wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  ctrl_word_t        ctrl_i,
  input  logic [`WB_DW-1:0] stat_i,
  input  seq_cnt_t          seq_i,
  output logic [`WB_DW-1:0] wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  output logic              ctrl_wr_o,
  output ctrl_word_t        ctrl_dat_o,
  output byte_sel_t         ctrl_sel_o
);

  logic [1:0]        word;    // Word index of the current access.
  logic              in_map;
  logic              legal;
  logic              req;     // New access, no response pending.
  logic [1:0]        word_q;  // Word index for the response cycle.
  logic [`WB_DW-1:0] rd_mux;

  assign word   = wb_adr_i[3:2];
  assign in_map = ~|wb_adr_i[`WB_DW-1:4] &&
                  (word == `ADDR_CTRL || word == `ADDR_STAT || word == `ADDR_SEQ);
  assign legal  = in_map && (!wb_we_i || word == `ADDR_CTRL);  // Status words read-only.
  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req & legal;
      wb_err_o <= req & ~legal;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      word_q <= word;
    end
  end

  // Control write lands in the same edge that raises ack.
  assign ctrl_wr_o  = req & wb_we_i & legal;
  assign ctrl_dat_o = wb_dat_i;
  assign ctrl_sel_o = wb_sel_i;

  always_comb begin
    case (word_q)
      `ADDR_CTRL: rd_mux = ctrl_i;
      `ADDR_STAT: rd_mux = stat_i;
      `ADDR_SEQ:  rd_mux = {{(`WB_DW-`WB_SEQW){1'b0}}, seq_i};
      default:    rd_mux = '0;
    endcase
  end

  assign wb_dat_o = wb_ack_o ? rd_mux : '0;  // Zero outside the ack cycle.

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o)
  ) else $error("wb_bus_slave: ack and err together");

endmodule

// ==== status_reg_path.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module status_reg_path import wb_reg_pkg::*; (
  input  logic              user_clk,
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic [`WB_DW-1:0] user_data_i,
  input  logic              user_valid_i,
  output logic [`WB_DW-1:0] stat_o,
  output seq_cnt_t          seq_o
);

  logic [`SYNC_STAGES-1:0] user_rst_q;  // wb_rst_i seen in user_clk.
  logic                    user_rst;
  logic [`WB_DW-1:0]       sample_q;    // Latest application sample.
  seq_cnt_t                seq_q;       // Counts every user_valid_i.
  logic                    pending_q;
  logic                    busy;
  logic                    load;
  status_snap_t            snap_src;
  status_snap_t            snap_dst;
  logic                    snap_valid;

  always_ff @(posedge user_clk) begin
    user_rst_q <= {user_rst_q[`SYNC_STAGES-2:0], wb_rst_i};
  end

  assign user_rst = user_rst_q[`SYNC_STAGES-1];

  always_ff @(posedge user_clk) begin
    if (user_valid_i) begin
      sample_q <= user_data_i;
    end
  end

  assign load = pending_q & ~busy;

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      seq_q     <= '0;
      pending_q <= 1'b0;
    end else begin
      if (user_valid_i) begin
        seq_q <= seq_q + seq_cnt_t'(1);  // Wraps modulo 256.
      end
      pending_q <= user_valid_i | (pending_q & ~load);
    end
  end

  assign snap_src.value = sample_q;
  assign snap_src.seq   = seq_q;

  cdc_handshake #(
    .payload_t (status_snap_t)
  ) i_cdc_status (
    .src_clk_i (user_clk),
    .src_rst_i (user_rst),
    .dst_clk_i (wb_clk_i),
    .load_i    (load),
    .data_i    (snap_src),
    .busy_o    (busy),
    .data_o    (snap_dst),
    .valid_o   (snap_valid)
  );

  // Bus-side copy, read by the slave.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      stat_o <= '0;
      seq_o  <= '0;
    end else if (snap_valid) begin
      stat_o <= snap_dst.value;
      seq_o  <= snap_dst.seq;
    end
  end

endmodule

// ==== ctrl_reg_path.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module ctrl_reg_path import wb_reg_pkg::*; (
  input  logic              wb_clk_i,
  input  logic              wb_rst_i,
  input  logic              user_clk,
  input  logic              wr_i,
  input  ctrl_word_t        wr_dat_i,
  input  byte_sel_t         wr_sel_i,
  output ctrl_word_t        ctrl_o,
  output logic [`WB_DW-1:0] user_data_o,
  output logic              user_update_o
);

  ctrl_word_t ctrl_q;     // Bus-side control buffer.
  ctrl_word_t merged;     // Buffer with the write lanes applied.
  logic       pending_q;  // Buffer not yet sent across.
  logic       busy;
  logic       load;

  // Lane b covers bits 8*b+7 down to 8*b.
  always_comb begin
    merged = ctrl_q;
    for (int b = 0; b < `WB_DW/8; b++) begin
      if (wr_sel_i[b]) begin
        merged[8*b +: 8] = wr_dat_i[8*b +: 8];
      end
    end
  end

  assign load = pending_q & ~busy;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ctrl_q    <= '0;
      pending_q <= 1'b0;
    end else begin
      if (wr_i) begin
        ctrl_q <= merged;
      end
      // A write in the load cycle keeps the flag for the next crossing.
      pending_q <= wr_i | (pending_q & ~load);
    end
  end

  assign ctrl_o = ctrl_q;

  cdc_handshake #(
    .payload_t (ctrl_word_t)
  ) i_cdc_ctrl (
    .src_clk_i (wb_clk_i),
    .src_rst_i (wb_rst_i),
    .dst_clk_i (user_clk),
    .load_i    (load),
    .data_i    (ctrl_q),
    .busy_o    (busy),
    .data_o    (user_data_o),    // Held until the next arrival.
    .valid_o   (user_update_o)   // One user_clk pulse per arrival.
  );

endmodule

// ==== cdc_handshake.sv ====
`timescale 1ns/10ps
`include "wb_reg_consts.svh"

module cdc_handshake import wb_reg_pkg::*; #(
  parameter type payload_t = ctrl_word_t
) (
  input  logic     src_clk_i,
  input  logic     src_rst_i,
  input  logic     dst_clk_i,
  input  logic     load_i,
  input  payload_t data_i,
  output logic     busy_o,
  output payload_t data_o,
  output logic     valid_o
);

  payload_t                src_data_q;  // Held while req is up.
  logic                    req_q;       // Source request.
  logic [`SYNC_STAGES-1:0] ack_sync_q;  // Ack into source domain.
  logic                    ack_seen;
  logic [`SYNC_STAGES-1:0] rst_sync_q;  // Source reset into destination.
  logic                    dst_rst;
  logic [`SYNC_STAGES-1:0] req_sync_q;  // Req into destination domain.
  logic                    req_seen;
  logic                    ack_q;       // Destination acknowledge.

  assign ack_seen = ack_sync_q[`SYNC_STAGES-1];
  assign busy_o   = req_q | ack_seen;  // Idle only with req and ack both low.

  always_ff @(posedge src_clk_i) begin
    if (load_i) begin
      src_data_q <= data_i;
    end
  end

  always_ff @(posedge src_clk_i) begin
    if (src_rst_i) begin
      req_q      <= 1'b0;
      ack_sync_q <= '0;
    end else begin
      ack_sync_q <= {ack_sync_q[`SYNC_STAGES-2:0], ack_q};
      if (load_i) begin
        req_q <= 1'b1;
      end else if (ack_seen) begin
        req_q <= 1'b0;  // Phase 3.
      end
    end
  end

  always_ff @(posedge dst_clk_i) begin
    rst_sync_q <= {rst_sync_q[`SYNC_STAGES-2:0], src_rst_i};
  end

  assign dst_rst  = rst_sync_q[`SYNC_STAGES-1];
  assign req_seen = req_sync_q[`SYNC_STAGES-1];

  // Latch on the rising edge of the synchronized request, then follow it.
  always_ff @(posedge dst_clk_i) begin
    if (dst_rst) begin
      req_sync_q <= '0;
      ack_q      <= 1'b0;
      valid_o    <= 1'b0;
      data_o     <= '0;
    end else begin
      req_sync_q <= {req_sync_q[`SYNC_STAGES-2:0], req_q};
      ack_q      <= req_seen;  // Phases 2 and 4.
      valid_o    <= req_seen & ~ack_q;
      if (req_seen && !ack_q) begin
        data_o <= src_data_q;
      end
    end
  end

  a_no_load_busy: assert property (
    @(posedge src_clk_i) disable iff (src_rst_i) load_i |-> !busy_o
  ) else $error("cdc_handshake: load while crossing busy");

  a_data_stable: assert property (
    @(posedge dst_clk_i) disable iff (dst_rst) ack_q |=> $stable(data_o)
  ) else $error("cdc_handshake: data_o changed while ack high");

endmodule

// ==== wb_reg_pkg.sv ====
`include "wb_reg_consts.svh"

package wb_reg_pkg;

  // Control word as written by the bus host.
  typedef logic [`WB_DW-1:0] ctrl_word_t;

  // One select bit per byte lane.
  typedef logic [`WB_DW/8-1:0] byte_sel_t;

  // Status update counter, wraps at 256.
  typedef logic [`WB_SEQW-1:0] seq_cnt_t;

  // Status snapshot; value and count cross together.
  typedef struct packed {
    logic [`WB_DW-1:0] value;  // Latest application sample.
    seq_cnt_t          seq;    // Count at the time of the sample.
  } status_snap_t;

endpackage

// ==== wb_reg_consts.svh ====
`ifndef WB_REG_CONSTS_SVH
`define WB_REG_CONSTS_SVH

// Bus data width in bits.
`define WB_DW 32

// Width of the status update counter.
`define WB_SEQW 8

// Word addresses, compared against wb_adr_i[3:2].
`define ADDR_CTRL 2'd0
`define ADDR_STAT 2'd1
`define ADDR_SEQ  2'd2

// Flops in each synchronizer chain.
`define SYNC_STAGES 2

`endif
